//--- rtl/dct_types_pkg.sv
package dct_types_pkg;

    // ==================================================================
    // Field widths
    // ==================================================================
    localparam int WORD_W   = 32;
    localparam int SAMPLE_W = 16;
    localparam int COS_W    = 16;  // Q1.14 cosine
    localparam int CPROD_W  = 30;  // cos x cos, magnitude up to 2^28
    localparam int ACC_W    = 50;  // 64 terms of sample x cos x cos
    localparam int ADDR_W   = 6;
    localparam int IDX_W    = 5;   // Angle index in units of pi/16

    typedef logic        [WORD_W-1:0]   word_t;
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COS_W-1:0]    cos_t;
    typedef logic signed [ACC_W-1:0]    acc_t;
    typedef logic        [ADDR_W-1:0]   addr_t;

    // Normalization class of an output coefficient
    typedef enum logic [1:0] {
        SCALE_SEL_DC    = 2'd0,  // i == 0 and j == 0
        SCALE_SEL_EDGE  = 2'd1,  // exactly one of i, j is 0
        SCALE_SEL_INNER = 2'd2
    } scale_sel_e;

    // One MAC term as issued by the sequencer
    typedef struct packed {
        logic             valid;
        logic             first;      // col == 0 and row == 0
        logic             last;       // col == 7 and row == 7
        logic [IDX_W-1:0] cos_a_idx;
        logic [IDX_W-1:0] cos_b_idx;
        scale_sel_e       scale_sel;
        addr_t            out_addr;   // 8*i + j
    } mac_term_t;

    typedef struct packed {
        logic  valid;
        logic  last;       // Final coefficient of the block
        addr_t out_addr;
        word_t value;
    } mac_result_t;

endpackage

//--- rtl/dct_const_pkg.sv
package dct_const_pkg;

    // ==================================================================
    // Block geometry
    // ==================================================================
    localparam int BLOCK_DIM   = 8;
    localparam int BLOCK_WORDS = BLOCK_DIM * BLOCK_DIM;

    // ==================================================================
    // Cosine table, entry k = round(16384 * cos(k*pi/16))
    // ==================================================================
    // Every angle of the 8-point DCT is a multiple of pi/16, so the
    // index (2k+1)u mod 32 covers one full turn
    localparam dct_types_pkg::cos_t COS_LUT [0:31] = '{
        16'sd16384,  16'sd16069,  16'sd15137,  16'sd13623,   // 0..3
        16'sd11585,  16'sd9102,   16'sd6270,   16'sd3196,    // 4..7
        16'sd0,     -16'sd3196,  -16'sd6270,  -16'sd9102,    // 8..11
       -16'sd11585, -16'sd13623, -16'sd15137, -16'sd16069,   // 12..15
       -16'sd16384, -16'sd16069, -16'sd15137, -16'sd13623,   // 16..19
       -16'sd11585, -16'sd9102,  -16'sd6270,  -16'sd3196,    // 20..23
        16'sd0,      16'sd3196,   16'sd6270,   16'sd9102,    // 24..27
        16'sd11585,  16'sd13623,  16'sd15137,  16'sd16069    // 28..31
    };

    // ==================================================================
    // Output scaling
    // ==================================================================
    // Applied as (acc * scale) >>> SCALE_SHIFT. The cos x cos product
    // carries 2^28, so 2^43 = 2^28 * 2^15 leaves scale/32768
    localparam int SCALE_DC    = 4096;  // 1/8
    localparam int SCALE_EDGE  = 5793;  // 1/(4*sqrt(2))
    localparam int SCALE_INNER = 8192;  // 1/4
    localparam int SCALE_SHIFT = 43;

endpackage

//--- rtl/dct_block_buffer.sv
`timescale 1ns/1ps

module dct_block_buffer #(
    parameter type payload_t = dct_types_pkg::word_t
) (
    input  logic                 clk,
    input  logic                 wr_en_i,
    input  dct_types_pkg::addr_t wr_addr_i,
    input  payload_t             wr_data_i,
    input  dct_types_pkg::addr_t rd_addr_i,
    output payload_t             rd_data_o
);
    import dct_const_pkg::*;

    payload_t mem [BLOCK_WORDS];

    // Write lands at the edge, read data follows one cycle later
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

//--- rtl/dct_index_seq.sv
`timescale 1ns/1ps

module dct_index_seq (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start_i,
    output dct_types_pkg::addr_t     rd_addr_o,
    output dct_types_pkg::mac_term_t term_o
);
    import dct_types_pkg::*;
    import dct_const_pkg::*;

    logic             running;
    logic [2:0]       i_cnt, j_cnt, col_cnt, row_cnt;
    logic             row_last, col_last, j_last, i_last;
    logic [IDX_W-1:0] col_odd, row_odd;
    scale_sel_e       scale_sel;

    assign row_last = (row_cnt == 3'(BLOCK_DIM - 1));
    assign col_last = (col_cnt == 3'(BLOCK_DIM - 1));
    assign j_last   = (j_cnt == 3'(BLOCK_DIM - 1));
    assign i_last   = (i_cnt == 3'(BLOCK_DIM - 1));

    assign rd_addr_o = {col_cnt, row_cnt};  // 8*col + row
    assign col_odd   = {1'b0, col_cnt, 1'b1};
    assign row_odd   = {1'b0, row_cnt, 1'b1};

    always_comb begin
        if (i_cnt == 3'd0 && j_cnt == 3'd0) begin
            scale_sel = SCALE_SEL_DC;
        end else if (i_cnt == 3'd0 || j_cnt == 3'd0) begin
            scale_sel = SCALE_SEL_EDGE;
        end else begin
            scale_sel = SCALE_SEL_INNER;
        end
    end

    // ==================================================================
    // Sweep i, j, col, row with row innermost
    // ==================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
            i_cnt   <= '0;
            j_cnt   <= '0;
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (start_i) begin
            running <= 1'b1;
            i_cnt   <= '0;
            j_cnt   <= '0;
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (running) begin
            row_cnt <= row_cnt + 3'd1;  // Counters wrap at 8
            if (row_last) begin
                col_cnt <= col_cnt + 3'd1;
                if (col_last) begin
                    j_cnt <= j_cnt + 3'd1;
                    if (j_last) begin
                        i_cnt <= i_cnt + 3'd1;
                        if (i_last) begin
                            running <= 1'b0;  // 4096th term issued
                        end
                    end
                end
            end
        end
    end

    // Registered term lines up with the buffer read data
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            term_o <= '0;
        end else begin
            term_o.valid     <= running;
            term_o.first     <= running && col_cnt == 3'd0 && row_cnt == 3'd0;
            term_o.last      <= running && col_last && row_last;
            term_o.cos_a_idx <= col_odd * IDX_W'(i_cnt);  // mod 32 by width
            term_o.cos_b_idx <= row_odd * IDX_W'(j_cnt);
            term_o.scale_sel <= scale_sel;
            term_o.out_addr  <= {i_cnt, j_cnt};
        end
    end

endmodule

//--- rtl/dct_mac_pipe.sv
`timescale 1ns/1ps

module dct_mac_pipe (
    input  logic                       clk,
    input  logic                       rst,
    input  dct_types_pkg::mac_term_t   term_i,
    input  dct_types_pkg::sample_t     sample_i,
    output dct_types_pkg::mac_result_t result_o
);
    import dct_types_pkg::*;
    import dct_const_pkg::*;

    cos_t                       cos_a, cos_b;
    logic signed [2*COS_W-1:0]  cos_prod;
    logic signed [15:0]         scale_val;
    logic signed [63:0]         scaled;

    mac_term_t                  s1_term, s2_term, s3_term;
    logic signed [CPROD_W-1:0]  s1_cprod;
    sample_t                    s1_sample;
    acc_t                       s2_prod;
    acc_t                       s3_acc;

    assign cos_a    = COS_LUT[term_i.cos_a_idx];
    assign cos_b    = COS_LUT[term_i.cos_b_idx];
    assign cos_prod = (2*COS_W)'(cos_a) * (2*COS_W)'(cos_b);

    always_comb begin
        case (s3_term.scale_sel)
            SCALE_SEL_DC:   scale_val = 16'(SCALE_DC);
            SCALE_SEL_EDGE: scale_val = 16'(SCALE_EDGE);
            default:        scale_val = 16'(SCALE_INNER);
        endcase
    end

    assign scaled = 64'(s3_acc) * 64'(scale_val);

    // ==================================================================
    // Flags and addresses ride along with the data
    // ==================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_term  <= '0;
            s2_term  <= '0;
            s3_term  <= '0;
            result_o <= '0;
        end else begin
            s1_term <= term_i;
            s2_term <= s1_term;
            s3_term <= s2_term;
            // Stage 4 emits one coefficient per 64 terms
            result_o.valid    <= s3_term.valid && s3_term.last;
            result_o.last     <= s3_term.valid && s3_term.last
                                 && s3_term.out_addr == addr_t'(BLOCK_WORDS - 1);
            result_o.out_addr <= s3_term.out_addr;
            result_o.value    <= word_t'(scaled >>> SCALE_SHIFT);  // floor
        end
    end

    // ==================================================================
    // Datapath stages 1 to 3
    // ==================================================================
    always_ff @(posedge clk) begin
        s1_cprod  <= cos_prod[CPROD_W-1:0];  // Fits, |cos x cos| <= 2^28
        s1_sample <= sample_i;
        s2_prod   <= acc_t'(s1_cprod) * acc_t'(s1_sample);
        if (s2_term.valid) begin
            s3_acc <= s2_term.first ? s2_prod : s3_acc + s2_prod;
        end
    end

endmodule

//--- rtl/dct_ctrl.sv
`timescale 1ns/1ps

module dct_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  dct_types_pkg::word_t   in_data_i,
    input  logic                   in_empty_n_i,
    output logic                   in_read_o,
    output logic                   smp_wr_en_o,
    output dct_types_pkg::addr_t   smp_wr_addr_o,
    output dct_types_pkg::sample_t smp_wr_data_o,
    output logic                   calc_start_o,
    input  logic                   calc_done_i,
    output dct_types_pkg::addr_t   res_rd_addr_o,
    input  dct_types_pkg::word_t   res_rd_data_i,
    output dct_types_pkg::word_t   out_data_o,
    output logic                   out_last_o,
    input  logic                   out_full_n_i,
    output logic                   out_write_o
);
    import dct_types_pkg::*;
    import dct_const_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_LOAD, ST_CALC, ST_WRITE, ST_FINISH
    } state_t;

    state_t state;
    addr_t  load_cnt;   // Samples accepted
    addr_t  out_cnt;    // Result presented on out_data_o
    logic   out_vld;    // res_rd_data_i holds result out_cnt
    logic   in_xfer;
    logic   out_fire;

    assign in_read_o = (state == ST_LOAD);
    assign in_xfer   = in_read_o && in_empty_n_i;

    assign smp_wr_en_o   = in_xfer;
    assign smp_wr_addr_o = load_cnt;
    assign smp_wr_data_o = sample_t'(in_data_i[SAMPLE_W-1:0]);  // Low half only

    // Output word stays put while the address is held
    assign out_write_o   = out_vld && out_full_n_i;
    assign out_fire      = out_write_o;
    assign out_last_o    = out_fire && out_cnt == addr_t'(BLOCK_WORDS - 1);
    assign out_data_o    = res_rd_data_i;
    assign res_rd_addr_o = out_fire ? out_cnt + addr_t'(1) : out_cnt;  // Prefetch

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            load_cnt     <= '0;
            out_cnt      <= '0;
            out_vld      <= 1'b0;
            calc_start_o <= 1'b0;
        end else begin
            calc_start_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    load_cnt <= '0;
                    out_cnt  <= '0;
                    if (in_empty_n_i) state <= ST_LOAD;
                end
                ST_LOAD: begin
                    if (in_xfer) begin
                        load_cnt <= load_cnt + addr_t'(1);
                        if (load_cnt == addr_t'(BLOCK_WORDS - 1)) begin
                            calc_start_o <= 1'b1;
                            state        <= ST_CALC;
                        end
                    end
                end
                ST_CALC: begin
                    if (calc_done_i) begin
                        out_vld <= 1'b1;  // Result 0 is already being read
                        state   <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (out_fire) begin
                        out_cnt <= out_cnt + addr_t'(1);
                        if (out_last_o) begin
                            out_vld <= 1'b0;
                            state   <= ST_FINISH;
                        end
                    end
                end
                default: state <= ST_IDLE;  // Finish lasts one cycle
            endcase
        end
    end

endmodule

//--- rtl/dct_core.sv
`timescale 1ns/1ps

module dct_core (
    input  logic                 clk,
    input  logic                 rst,
    input  dct_types_pkg::word_t in_data_i,
    input  logic                 in_empty_n_i,
    output logic                 in_read_o,
    output dct_types_pkg::word_t out_data_o,
    output logic                 out_last_o,
    input  logic                 out_full_n_i,
    output logic                 out_write_o
);
    import dct_types_pkg::*;

    logic        smp_wr_en;
    addr_t       smp_wr_addr;
    sample_t     smp_wr_data;
    addr_t       smp_rd_addr;
    sample_t     smp_rd_data;
    logic        calc_start;
    mac_term_t   mac_term;
    mac_result_t mac_result;
    addr_t       res_rd_addr;
    word_t       res_rd_data;

    // ==================================================================
    // Control and load/store
    // ==================================================================
    dct_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .in_data_i     (in_data_i),
        .in_empty_n_i  (in_empty_n_i),
        .in_read_o     (in_read_o),
        .smp_wr_en_o   (smp_wr_en),
        .smp_wr_addr_o (smp_wr_addr),
        .smp_wr_data_o (smp_wr_data),
        .calc_start_o  (calc_start),
        .calc_done_i   (mac_result.last),
        .res_rd_addr_o (res_rd_addr),
        .res_rd_data_i (res_rd_data),
        .out_data_o    (out_data_o),
        .out_last_o    (out_last_o),
        .out_full_n_i  (out_full_n_i),
        .out_write_o   (out_write_o)
    );

    dct_block_buffer #(.payload_t(sample_t)) u_sample_buf (
        .clk       (clk),
        .wr_en_i   (smp_wr_en),
        .wr_addr_i (smp_wr_addr),
        .wr_data_i (smp_wr_data),
        .rd_addr_i (smp_rd_addr),
        .rd_data_o (smp_rd_data)
    );

    // ==================================================================
    // Compute path
    // ==================================================================
    dct_index_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .start_i   (calc_start),
        .rd_addr_o (smp_rd_addr),
        .term_o    (mac_term)
    );

    dct_mac_pipe u_mac (
        .clk      (clk),
        .rst      (rst),
        .term_i   (mac_term),
        .sample_i (smp_rd_data),
        .result_o (mac_result)
    );

    dct_block_buffer #(.payload_t(word_t)) u_result_buf (
        .clk       (clk),
        .wr_en_i   (mac_result.valid),
        .wr_addr_i (mac_result.out_addr),
        .wr_data_i (mac_result.value),
        .rd_addr_i (res_rd_addr),
        .rd_data_o (res_rd_data)
    );

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;  // 10 ns period
    end

endmodule

//--- verif/dct_checker.sv
`timescale 1ns/1ps

module dct_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  dct_types_pkg::word_t in_data_i,
    input  logic                 in_empty_n_i,
    input  logic                 in_read_i,
    input  dct_types_pkg::word_t out_data_i,
    input  logic                 out_last_i,
    input  logic                 out_full_n_i,
    input  logic                 out_write_i,
    output int                   err_cnt_o,
    output int                   test_cnt_o
);
    import dct_types_pkg::*;
    import dct_const_pkg::*;

    localparam real PI = 3.14159265358979323846;

    int      cos_ref [32];     // round(16384 * cos(k*pi/16))
    sample_t smp [BLOCK_WORDS];
    word_t   exp_q [$];        // Expected words in address order
    addr_t   in_cnt   = '0;
    addr_t   out_cnt  = '0;
    int      post_rst = 0;     // Rising edges since reset release
    int      err_cnt  = 0;
    int      test_cnt = 0;
    int      blk_err  = 0;

    assign err_cnt_o  = err_cnt;
    assign test_cnt_o = test_cnt;

    function automatic int round_real(real x);
        if (x >= 0.0) begin
            return $rtoi(x + 0.5);
        end
        return -$rtoi(0.5 - x);
    endfunction

    // Coefficient (i,j) of the captured block, straight from the DCT sum
    function automatic word_t model_coef(int i, int j);
        longint acc;
        longint scale;
        longint res;
        acc = 0;
        for (int col = 0; col < BLOCK_DIM; col++) begin
            for (int row = 0; row < BLOCK_DIM; row++) begin
                acc += longint'(smp[addr_t'(BLOCK_DIM * col + row)])
                       * longint'(cos_ref[5'((2 * col + 1) * i)])
                       * longint'(cos_ref[5'((2 * row + 1) * j)]);
            end
        end
        if (i == 0 && j == 0) begin
            scale = 64'sd4096;
        end else if (i == 0 || j == 0) begin
            scale = 64'sd5793;
        end else begin
            scale = 64'sd8192;
        end
        res = (acc * scale) >>> 43;  // Floor
        return res[31:0];
    endfunction

    task automatic count_error();
        err_cnt++;
        blk_err++;
    endtask

    initial begin
        for (int k = 0; k < 32; k++) begin
            cos_ref[5'(k)] = round_real(16384.0 * $cos(real'(k) * PI / 16.0));
        end
    end

    // ==================================================================
    // Port monitor
    // ==================================================================
    always @(posedge clk) begin
        word_t exp_word;
        logic  last_exp;
        if (rst || post_rst < 2) begin  // Reset and the cycle after it
            if (in_read_i || out_write_i || out_last_i) begin
                $display("Strobe active at %0t during reset or right after it", $time);
                count_error();
            end
        end
        if (rst) begin
            post_rst = 0;
        end else if (post_rst < 2) begin
            post_rst++;
            if (post_rst == 2) begin
                test_cnt++;
                $display("Test %0d: reset, strobes quiet, %0d errors", test_cnt, blk_err);
                blk_err = 0;
            end
        end

        if (!rst && in_read_i && in_empty_n_i) begin
            if (exp_q.size() != 0) begin
                $display("Input word taken at %0t while the previous block is still pending",
                         $time);
                count_error();
            end
            smp[in_cnt] = sample_t'(in_data_i[15:0]);  // Sample sits in the low half
            if (in_cnt == addr_t'(BLOCK_WORDS - 1)) begin
                for (int n = 0; n < BLOCK_WORDS; n++) begin
                    exp_q.push_back(model_coef(n / BLOCK_DIM, n % BLOCK_DIM));
                end
            end
            in_cnt++;
        end

        if (!rst && out_write_i) begin
            if (!out_full_n_i) begin
                $display("Write at %0t while the output FIFO has no room", $time);
                count_error();
            end
            if (in_read_i) begin
                $display("Read and write strobes high together at %0t", $time);
                count_error();
            end
            if (exp_q.size() == 0) begin
                $display("Write at %0t with no result expected", $time);
                count_error();
            end else begin
                exp_word = exp_q.pop_front();
                last_exp = (out_cnt == addr_t'(BLOCK_WORDS - 1));
                if (out_data_i !== exp_word) begin
                    $display("[FAIL] %0t out_data_o word %0d: expected %08h, actual %08h",
                             $time, out_cnt, exp_word, out_data_i);
                    count_error();
                end
                if (out_last_i !== last_exp) begin
                    $display("[FAIL] %0t out_last_o word %0d: expected %0b, actual %0b",
                             $time, out_cnt, last_exp, out_last_i);
                    count_error();
                end
                if (last_exp) begin
                    test_cnt++;
                    $display("Test %0d: block of %0d coefficients, %0d errors",
                             test_cnt, BLOCK_WORDS, blk_err);
                    blk_err = 0;
                end
                out_cnt++;
            end
        end else if (!rst && out_last_i) begin
            $display("out_last_o high at %0t without a write", $time);
            count_error();
        end
    end

endmodule

//--- verif/dct_asserts.sv
`timescale 1ns/1ps

module dct_asserts (
    input logic clk,
    input logic rst,
    input logic in_read_i,
    input logic out_last_i,
    input logic out_full_n_i,
    input logic out_write_i
);

    a_write_room: assert property (@(posedge clk) disable iff (rst)
        out_write_i |-> out_full_n_i)
        else $error("out_write_o high while out_full_n_i is low");

    a_last_write: assert property (@(posedge clk) disable iff (rst)
        out_last_i |-> out_write_i)
        else $error("out_last_o high without out_write_o");

    // Load and write phases never overlap
    a_read_write: assert property (@(posedge clk) disable iff (rst)
        !(in_read_i && out_write_i))
        else $error("in_read_o and out_write_o high together");

endmodule

bind dct_core dct_asserts u_asserts (
    .clk          (clk),
    .rst          (rst),
    .in_read_i    (in_read_o),
    .out_last_i   (out_last_o),
    .out_full_n_i (out_full_n_i),
    .out_write_i  (out_write_o)
);

//--- verif/tb_top.sv
`timescale 1ns/1ps

module tb_top;
    import dct_types_pkg::*;
    import dct_const_pkg::*;

    localparam int NUM_BLOCKS   = 6;
    localparam int STALL_FROM   = 4;  // Later blocks see random stalls on both sides
    localparam int RESET_CYCLES = 16;
    // Load, calculate, write and slack per block, four times over for stalls
    localparam int WATCHDOG_NS  = NUM_BLOCKS * (64 + 4096 + 64 + 16) * 4 * 10;

    logic        clk;
    logic        rst;
    word_t       in_data;
    logic        in_empty_n;
    logic        in_read;
    word_t       out_data;
    logic        out_last;
    logic        out_full_n;
    logic        out_write;
    int          err_cnt;
    int          test_cnt;
    logic [31:0] lcg_state;
    logic        stall_en;
    word_t       blk_words [BLOCK_WORDS];

    tb_clock_gen u_clk_gen (
        .clk_o (clk)
    );

    dct_core u_dut (
        .clk          (clk),
        .rst          (rst),
        .in_data_i    (in_data),
        .in_empty_n_i (in_empty_n),
        .in_read_o    (in_read),
        .out_data_o   (out_data),
        .out_last_o   (out_last),
        .out_full_n_i (out_full_n),
        .out_write_o  (out_write)
    );

    dct_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .in_data_i    (in_data),
        .in_empty_n_i (in_empty_n),
        .in_read_i    (in_read),
        .out_data_i   (out_data),
        .out_last_i   (out_last),
        .out_full_n_i (out_full_n),
        .out_write_i  (out_write),
        .err_cnt_o    (err_cnt),
        .test_cnt_o   (test_cnt)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ==================================================================
    // Input and output sides of one block
    // ==================================================================
    task automatic send_block();
        logic [31:0] r;
        int          k;
        k = 0;
        while (k < BLOCK_WORDS) begin
            @(negedge clk);
            r          = next_rand();
            in_data    = blk_words[addr_t'(k)];
            in_empty_n = stall_en ? r[31] : 1'b1;
            out_full_n = stall_en ? r[30] : 1'b1;
            if (in_read && in_empty_n) begin  // Taken at the coming rising edge
                k++;
            end
        end
        @(negedge clk);
        in_empty_n = 1'b0;
    endtask

    task automatic drain_block();
        logic [31:0] r;
        logic        done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            r          = next_rand();
            out_full_n = stall_en ? r[30] : 1'b1;
            @(posedge clk);
            done = out_write && out_last;  // Last word leaves at this edge
        end
        @(negedge clk);
        out_full_n = 1'b1;
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================
    initial begin
        logic [31:0] r;
        logic [15:0] cval;
        lcg_state  = 32'h424e_b1c0;
        rst        = 1'b1;
        in_data    = '0;
        in_empty_n = 1'b0;
        out_full_n = 1'b1;
        stall_en   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int b = 0; b < NUM_BLOCKS; b++) begin
            stall_en = (b >= STALL_FROM);
            r        = next_rand();
            cval     = r[31:16];
            for (int k = 0; k < BLOCK_WORDS; k++) begin
                r = next_rand();
                if (b == 0) begin
                    blk_words[addr_t'(k)] = {r[15:0], cval};  // Constant block
                end else begin
                    blk_words[addr_t'(k)] = {r[15:0], r[31:16]};  // Junk in upper half
                end
            end
            send_block();
            drain_block();
        end

        repeat (4) @(negedge clk);
        $display("Tests run: %0d, errors: %0d", test_cnt, err_cnt);
        if (err_cnt == 0 && test_cnt == NUM_BLOCKS + 1) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t, the DUT did not finish all blocks", $time);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- all.f
rtl/dct_types_pkg.sv
rtl/dct_const_pkg.sv
rtl/dct_block_buffer.sv
rtl/dct_index_seq.sv
rtl/dct_mac_pipe.sv
rtl/dct_ctrl.sv
rtl/dct_core.sv
verif/tb_clock_gen.sv
verif/dct_checker.sv
verif/dct_asserts.sv
verif/tb_top.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_top -f all.f -Mdir obj_dir -o tb_top_sim
	./obj_dir/tb_top_sim | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
